//--- Bender.yml
package:
  name: obi_atop_resolver

sources:
  # Packages first, the RTL modules depend on them
  - files:
      - verilog/atop_pkg.sv
      - verilog/obi_bus_pkg.sv
  - files:
      - verilog/atop_lrsc_monitor.sv
      - verilog/atop_amo_unit.sv
      - verilog/atop_req_arbiter.sv
      - verilog/atop_rsp_queue.sv
      - verilog/obi_atop_resolver.sv
  - target: test
    files:
      - dv/tb_obi_atop_resolver.sv

//--- dv/atop_golden.txt
// Columns in hex: kind op id addr wdata we rdata exokay
// kind 1 is a request with its expected response, kind 2 checks the final memory word at addr
1 00 1 00000000 11111111 1 00000000 0
1 00 2 00000004 DEADBEEF 1 00000000 0
1 00 3 00000008 80000000 1 00000000 0
1 00 1 00000000 00000000 0 11111111 0
1 00 2 00000004 00000000 0 DEADBEEF 0
1 00 3 00000008 00000000 0 80000000 0
// AMOs return the old word
1 00 4 00000010 00000005 1 00000000 0
1 20 5 00000010 00000003 1 00000005 0
1 21 5 00000010 0000000A 1 00000008 0
1 24 6 00000010 0000000F 1 0000000A 0
1 28 6 00000010 00000030 1 00000005 0
1 2C 7 00000010 0000003C 1 00000035 0
1 00 7 00000010 00000000 0 00000034 0
1 00 8 00000014 FFFFFFF0 1 00000000 0
1 30 8 00000014 00000004 1 FFFFFFF0 0
1 34 9 00000014 00000004 1 FFFFFFF0 0
1 30 9 00000014 FFFFFFFE 1 00000004 0
1 38 A 00000014 00000007 1 FFFFFFFE 0
1 3C A 00000014 80000001 1 00000007 0
1 34 B 00000014 FFFFFFFF 1 80000001 0
1 3C B 00000014 00000010 1 FFFFFFFF 0
1 38 B 00000014 00000010 1 FFFFFFFF 0
1 00 C 00000014 00000000 0 00000010 0
// LR and SC, SC answers 0 on success and 1 on failure
1 00 1 00000020 00000064 1 00000000 0
1 22 1 00000020 00000000 0 00000064 1
1 23 1 00000020 00000065 1 00000000 1
1 00 1 00000020 00000000 0 00000065 0
1 22 2 00000020 00000000 0 00000065 1
1 00 3 00000020 00000077 1 00000000 0
1 23 2 00000020 00000099 1 00000001 0
1 00 2 00000020 00000000 0 00000077 0
1 22 4 00000024 00000000 0 00000000 1
1 23 4 00000028 00000055 1 00000001 0
1 00 4 00000028 00000000 0 00000000 0
1 22 5 00000010 00000000 0 00000034 1
1 20 6 00000010 00000001 1 00000034 0
1 23 5 00000010 000000FF 1 00000001 0
1 00 6 00000010 00000000 0 00000035 0
// Final memory contents
2 00 0 00000000 00000000 0 11111111 0
2 00 0 00000004 00000000 0 DEADBEEF 0
2 00 0 00000008 00000000 0 80000000 0
2 00 0 00000010 00000000 0 00000035 0
2 00 0 00000014 00000000 0 00000010 0
2 00 0 00000020 00000000 0 00000077 0
2 00 0 00000028 00000000 0 00000000 0

//--- dv/tb_obi_atop_resolver.sv
// Testbench for the OBI atomic resolver
// Replays the golden transaction list on the subordinate port, answers the
// manager port from a word memory with random grant stalls and checks every
// response, the manager ID and the final memory contents.

`default_nettype none

module tb_obi_atop_resolver;
  import atop_pkg::*;
  import obi_bus_pkg::*;

  localparam int RecWords        = 8;
  localparam int MaxRecords      = 64;
  localparam int CyclesPerRecord = 40;

  typedef struct packed {
    id_t   id;
    word_t rdata;
    logic  exokay;
  } resp_exp_t;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      rready = 1'b0;
  logic      mem_gnt = 1'b0;
  logic      mem_rvalid = 1'b0;
  word_t     mem_rdata = '0;
  id_t       last_acc_id = '0;
  sbr_req_t  drv_req;
  sbr_req_t  sbr_req;
  sbr_rsp_t  sbr_rsp;
  mgr_req_t  mgr_req;
  mgr_rsp_t  mgr_rsp;

  word_t     golden [RecWords*MaxRecords];
  word_t     mem [256];
  resp_exp_t exp_q [$];
  int        n_records = 0;
  int        rsp_count = 0;
  int        rsp_mismatches = 0;
  int        rsp_errors = 0;
  int        mem_mismatches = 0;
  int        bus_mismatches = 0;
  int        other_errors = 0;

  always #4 clk = ~clk;

  always_comb begin
    sbr_req        = drv_req;
    sbr_req.rready = rready;
  end

  assign mgr_rsp = '{gnt: mem_gnt, rvalid: mem_rvalid, rdata: mem_rdata, err: 1'b0};

  obi_atop_resolver #(
    .LrScEnable(1'b1),
    .RspDepth  (2)
  ) obi_atop_resolver_i (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .sbr_req_i(sbr_req),
    .sbr_rsp_o(sbr_rsp),
    .mgr_req_o(mgr_req),
    .mgr_rsp_i(mgr_rsp)
  );

  // ----------------------------------------
  // Memory model
  // ----------------------------------------

  // Every grant is answered one cycle later and a read returns the word before the write
  always @(posedge clk) begin : memory_model
    logic       granted;
    word_t      read_word;
    logic [7:0] idx;
    id_t        want_aid;
    int         i;
    granted   = rst_n && mgr_req.req && mem_gnt;
    read_word = '0;
    idx       = mgr_req.addr[9:2];
    // A write-back keeps the subordinate grant low and carries the ID of the AMO
    want_aid  = sbr_rsp.gnt ? drv_req.aid : last_acc_id;
    if (!rst_n) begin
      for (i = 0; i < 256; i++) mem[i] = '0;
    end else if (granted) begin
      assert (mgr_req.aid == want_aid) else begin
        bus_mismatches++;
        $display("MISMATCH @%0t: manager aid %h, expected %h", $time, mgr_req.aid, want_aid);
      end
      if (mgr_req.we) begin
        for (i = 0; i < 4; i++) begin
          if (mgr_req.be[i]) mem[idx][i*8 +: 8] = mgr_req.wdata[i*8 +: 8];
        end
      end else begin
        read_word = mem[idx];
      end
    end
    #1;
    mem_rvalid = granted;
    mem_rdata  = read_word;
  end

  // Draws the memory grant stalls and the rready runs. Low runs are long
  // enough to fill the response queue
  initial begin : stall_driver
    int run_left;
    // The seeding draw also sets the length of the first low run of rready
    run_left = $urandom(32'h5cf3_6748) % 13;
    forever begin
      @(posedge clk);
      #1;
      mem_gnt = ($urandom_range(0, 3) != 0);
      if (run_left == 0) begin
        rready   = !rready;
        run_left = rready ? $urandom_range(1, 4) : $urandom_range(1, 12);
      end else begin
        run_left--;
      end
    end
  end

  // ----------------------------------------
  // Driver and checker
  // ----------------------------------------

  task automatic issue_request(input int base);
    resp_exp_t want;
    drv_req.req   = 1'b1;
    drv_req.atop  = atop_e'(golden[base+1][5:0]);
    drv_req.aid   = id_t'(golden[base+2]);
    drv_req.addr  = golden[base+3];
    drv_req.wdata = golden[base+4];
    drv_req.we    = golden[base+5][0];
    drv_req.be    = 4'hF;
    do begin
      @(posedge clk);
    end while (!sbr_rsp.gnt);
    want.id     = id_t'(golden[base+2]);
    want.rdata  = golden[base+6];
    want.exokay = golden[base+7][0];
    exp_q.push_back(want);
    last_acc_id = drv_req.aid;
    #1;
  endtask

  always @(posedge clk) begin : response_checker
    resp_exp_t want;
    if (rst_n && sbr_rsp.rvalid && rready) begin
      assert (exp_q.size() != 0) else begin
        rsp_errors++;
        $display("ERROR @%0t: response with rid %h arrived with no request outstanding",
                 $time, sbr_rsp.rid);
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        rsp_count++;
        assert (sbr_rsp.rid == want.id) else begin
          rsp_mismatches++;
          $display("MISMATCH @%0t: rid %h, expected %h", $time, sbr_rsp.rid, want.id);
        end
        assert (sbr_rsp.rdata == want.rdata) else begin
          rsp_mismatches++;
          $display("MISMATCH @%0t: rdata %h, expected %h (rid %h)",
                   $time, sbr_rsp.rdata, want.rdata, want.id);
        end
        assert (sbr_rsp.exokay == want.exokay) else begin
          rsp_mismatches++;
          $display("MISMATCH @%0t: exokay %b, expected %b (rid %h)",
                   $time, sbr_rsp.exokay, want.exokay, want.id);
        end
        assert (!sbr_rsp.err) else begin
          rsp_mismatches++;
          $display("MISMATCH @%0t: err set on rid %h", $time, want.id);
        end
      end
    end
  end

  initial begin : watchdog
    @(posedge rst_n);
    repeat (n_records * CyclesPerRecord) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, transactions did not complete",
             n_records * CyclesPerRecord);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    int    i;
    int    base;
    word_t addr;
    drv_req  = '0;
    rst_n    = 1'b0;
    for (i = 0; i < RecWords*MaxRecords; i++) golden[i] = '0;
    $readmemh("dv/atop_golden.txt", golden);
    while ((n_records < MaxRecords) && (golden[n_records*RecWords] != '0)) n_records++;
    assert (n_records > 0) else begin
      other_errors++;
      $display("ERROR: the golden file holds no records");
    end

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (i = 0; i < n_records; i++) begin
      base = i * RecWords;
      if (golden[base] == 32'd1) issue_request(base);
    end
    drv_req.req = 1'b0;

    // Drain the responses, then let a pending write-back reach memory
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    while (mgr_req.req) @(posedge clk);

    for (i = 0; i < n_records; i++) begin
      base = i * RecWords;
      if (golden[base] == 32'd2) begin
        addr = golden[base+3];
        assert (mem[addr[9:2]] == golden[base+6]) else begin
          mem_mismatches++;
          $display("MISMATCH @%0t: memory word at %h is %h, expected %h",
                   $time, addr, mem[addr[9:2]], golden[base+6]);
        end
      end
    end

    $display("Responses %0d: mismatches %0d rsp, %0d mem, %0d bus, other errors %0d",
             rsp_count, rsp_mismatches, mem_mismatches, bus_mismatches,
             rsp_errors + other_errors);
    if ((rsp_mismatches + mem_mismatches + bus_mismatches + rsp_errors + other_errors) == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
verilog/atop_pkg.sv
verilog/obi_bus_pkg.sv
verilog/atop_lrsc_monitor.sv
verilog/atop_amo_unit.sv
verilog/atop_req_arbiter.sv
verilog/atop_rsp_queue.sv
verilog/obi_atop_resolver.sv
dv/tb_obi_atop_resolver.sv

//--- verilog/atop_amo_unit.sv
// AMO execution unit
// Captures an accepted atomic, takes the old memory word from the read
// response and requests the write of the ALU result on the manager port.

`default_nettype none

module atop_amo_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               sbr_fire_i,
  input  atop_pkg::atop_e    atop_i,
  input  obi_bus_pkg::addr_t addr_i,
  input  obi_bus_pkg::id_t   aid_i,
  input  atop_pkg::word_t    wdata_i,
  input  logic               rvalid_i,
  input  atop_pkg::word_t    rdata_i,
  input  logic               wb_gnt_i,
  output logic               amo_busy_o,
  output logic               amo_rd_o,
  output obi_bus_pkg::addr_t wb_addr_o,
  output obi_bus_pkg::id_t   wb_aid_o,
  output atop_pkg::word_t    wb_data_o
);
  import atop_pkg::*;
  import obi_bus_pkg::*;

  typedef enum logic {
    AmoIdle,
    AmoWriteBack
  } amo_state_e;

  amo_state_e state_q, state_d;
  atop_e      op_q;
  addr_t      addr_q;
  id_t        aid_q;
  word_t      operand_b_q;
  word_t      mem_word_q;
  word_t      operand_a;
  word_t      result;
  logic       load_amo;
  logic       lt_signed;
  logic       lt_unsigned;

  assign load_amo   = sbr_fire_i && is_amo(atop_i);
  assign amo_busy_o = (state_q == AmoWriteBack);
  // The read half goes out with we forced low by the arbiter
  assign amo_rd_o   = (state_q == AmoIdle) && is_amo_read(atop_i);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      AmoIdle:      if (load_amo) state_d = AmoWriteBack;
      AmoWriteBack: if (wb_gnt_i) state_d = AmoIdle;
      default:      state_d = AmoIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= AmoIdle;
      op_q    <= ATOP_NONE;
    end else begin
      state_q <= state_d;
      if (load_amo) op_q <= atop_i;
    end
  end

  // Operands and the held memory word
  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      addr_q      <= addr_i;
      aid_q       <= aid_i;
      operand_b_q <= wdata_i;
    end
    if (amo_busy_o && rvalid_i) mem_word_q <= rdata_i;
  end

  // ----------------------------------------
  // ALU
  // ----------------------------------------

  // Memory answers in the first write-back cycle, later cycles use the copy
  assign operand_a   = rvalid_i ? rdata_i : mem_word_q;
  assign lt_signed   = $signed(operand_a) < $signed(operand_b_q);
  assign lt_unsigned = operand_a < operand_b_q;

  always_comb begin
    unique case (op_q)
      AMO_SWAP: result = operand_b_q;
      AMO_ADD:  result = operand_a + operand_b_q;
      AMO_XOR:  result = operand_a ^ operand_b_q;
      AMO_AND:  result = operand_a & operand_b_q;
      AMO_OR:   result = operand_a | operand_b_q;
      AMO_MIN:  result = lt_signed ? operand_a : operand_b_q;
      AMO_MAX:  result = lt_signed ? operand_b_q : operand_a;
      AMO_MINU: result = lt_unsigned ? operand_a : operand_b_q;
      AMO_MAXU: result = lt_unsigned ? operand_b_q : operand_a;
      default:  result = '0;
    endcase
  end

  assign wb_addr_o = addr_q;
  assign wb_aid_o  = aid_q;
  assign wb_data_o = result;

  // Memory must return the old word right after the read grant
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(amo_busy_o) |-> rvalid_i)
    else $error("No read data in the first AMO write-back cycle");

endmodule

`default_nettype wire

//--- verilog/atop_lrsc_monitor.sv
// LR/SC reservation monitor
// Tracks one reservation (address and requester) and decides whether a
// store-conditional may write to memory.

`default_nettype none

module atop_lrsc_monitor #(
  parameter bit LrScEnable = 1'b1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               sbr_fire_i,
  input  logic               we_i,
  input  obi_bus_pkg::addr_t addr_i,
  input  obi_bus_pkg::id_t   aid_i,
  input  atop_pkg::atop_e    atop_i,
  output logic               sc_we_o,
  output logic               is_sc_q_o,
  output logic               sc_ok_q_o
);
  import atop_pkg::*;
  import obi_bus_pkg::*;

  if (LrScEnable) begin : gen_lrsc
    typedef struct packed {
      logic  valid;
      addr_t addr;
      id_t   owner;
    } reservation_t;

    reservation_t res_q, res_d;
    logic         owner_match;
    logic         addr_match;
    logic         sc_ok_d;

    assign owner_match = res_q.valid && (res_q.owner == aid_i);
    assign addr_match  = (res_q.addr == addr_i);

    // Decided before the grant, so the manager write enable can follow it
    assign sc_we_o = (atop_i == ATOP_SC) && owner_match && addr_match;

    always_comb begin
      res_d   = res_q;
      sc_ok_d = 1'b0;
      if (sbr_fire_i) begin
        // A requester never steals a live reservation from another one
        if ((atop_i == ATOP_LR) && (!res_q.valid || (res_q.owner == aid_i))) begin
          res_d   = '{valid: 1'b1, addr: addr_i, owner: aid_i};
          sc_ok_d = 1'b1;
        end
        // Stores from anyone else to the reserved word break the reservation
        if ((res_q.owner != aid_i) && addr_match && (we_i || is_amo(atop_i))) begin
          res_d.valid = 1'b0;
        end
        if ((atop_i == ATOP_SC) && owner_match) begin
          res_d.valid = 1'b0;
          sc_ok_d     = addr_match;
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        res_q     <= '0;
        is_sc_q_o <= 1'b0;
        sc_ok_q_o <= 1'b0;
      end else begin
        res_q     <= res_d;
        is_sc_q_o <= sbr_fire_i && (atop_i == ATOP_SC);
        sc_ok_q_o <= sc_ok_d;
      end
    end
  end else begin : gen_no_lrsc
    assign sc_we_o   = 1'b0;
    assign is_sc_q_o = 1'b0;
    assign sc_ok_q_o = 1'b0;
  end

  // exokay may only come from an LR or an SC accepted one cycle earlier
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    sc_ok_q_o |-> (is_sc_q_o || $past(sbr_fire_i && (atop_i == ATOP_LR))))
    else $error("exokay raised without a preceding LR or SC");

endmodule

`default_nettype wire

//--- verilog/atop_pkg.sv
// RISC-V atomic opcodes
// Opcode encoding, the data word type and helpers that classify an opcode
// for the atomic resolver.

`default_nettype none

package atop_pkg;

  // One RISC-V data word, the only width the ALU handles
  typedef logic [31:0] word_t;

  // Code points follow the OBI atop field
  typedef enum logic [5:0] {
    ATOP_NONE = 6'h00,
    AMO_ADD   = 6'h20,
    AMO_SWAP  = 6'h21,
    ATOP_LR   = 6'h22,
    ATOP_SC   = 6'h23,
    AMO_XOR   = 6'h24,
    AMO_OR    = 6'h28,
    AMO_AND   = 6'h2C,
    AMO_MIN   = 6'h30,
    AMO_MAX   = 6'h34,
    AMO_MINU  = 6'h38,
    AMO_MAXU  = 6'h3C
  } atop_e;

  // Any atomic code that is neither LR nor SC is a read-modify-write
  function automatic logic is_amo(atop_e op);
    return op[5] && (op != ATOP_LR) && (op != ATOP_SC);
  endfunction

  // True for the nine operations the ALU implements
  function automatic logic is_amo_read(atop_e op);
    return op inside {AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR,
                      AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};
  endfunction

endpackage

`default_nettype wire

//--- verilog/atop_req_arbiter.sv
// Manager request arbiter
// Chooses between the subordinate request and the AMO write-back, applies
// the SC and AMO write-enable overrides and forms the subordinate grant.

`default_nettype none

module atop_req_arbiter (
  input  obi_bus_pkg::sbr_req_t sbr_req_i,
  input  logic                  mgr_gnt_i,
  input  logic                  rsp_room_i,
  input  logic                  sc_we_i,
  input  logic                  amo_busy_i,
  input  logic                  amo_rd_i,
  input  obi_bus_pkg::addr_t    wb_addr_i,
  input  obi_bus_pkg::id_t      wb_aid_i,
  input  atop_pkg::word_t       wb_data_i,
  output obi_bus_pkg::mgr_req_t mgr_req_o,
  output logic                  sbr_gnt_o,
  output logic                  sbr_fire_o,
  output logic                  wb_gnt_o,
  output logic                  wb_issue_o
);
  import atop_pkg::*;

  always_comb begin
    // Pass-through, held back while the response queue is full
    mgr_req_o.req   = sbr_req_i.req && rsp_room_i;
    mgr_req_o.we    = sbr_req_i.we;
    mgr_req_o.addr  = sbr_req_i.addr;
    mgr_req_o.wdata = sbr_req_i.wdata;
    mgr_req_o.be    = sbr_req_i.be;
    mgr_req_o.aid   = sbr_req_i.aid;
    if (sbr_req_i.atop == ATOP_SC) begin
      mgr_req_o.we = sc_we_i;
    end else if (amo_rd_i) begin
      mgr_req_o.we = 1'b0;
    end
    sbr_gnt_o = mgr_gnt_i && rsp_room_i;
    wb_gnt_o  = 1'b0;

    // The AMO write-back owns the port until memory takes it
    if (amo_busy_i) begin
      mgr_req_o = '{req: 1'b1, we: 1'b1, addr: wb_addr_i, wdata: wb_data_i,
                    be: '1, aid: wb_aid_i};
      sbr_gnt_o = 1'b0;
      wb_gnt_o  = mgr_gnt_i;
    end
  end

  assign sbr_fire_o = sbr_req_i.req && sbr_gnt_o;
  // The write-back response is not returned upstream
  assign wb_issue_o = wb_gnt_o;

  always_comb begin
    assert final (!(sbr_gnt_o && amo_busy_i))
      else $error("Subordinate granted during an AMO write-back");
  end

endmodule

`default_nettype wire

//--- verilog/atop_rsp_queue.sv
// Response queue
// Holds response IDs from accept time and read data from memory until the
// subordinate takes them. The data side falls through when empty.

`default_nettype none

module atop_rsp_queue #(
  parameter int RspDepth = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  sbr_fire_i,
  input  obi_bus_pkg::id_t      aid_i,
  input  logic                  wb_issue_i,
  input  logic                  mgr_rvalid_i,
  input  atop_pkg::word_t       mgr_rdata_i,
  input  logic                  mgr_err_i,
  input  logic                  is_sc_q_i,
  input  logic                  sc_ok_q_i,
  input  logic                  rready_i,
  output obi_bus_pkg::sbr_rsp_t rsp_o,
  output logic                  rsp_room_o
);
  import atop_pkg::*;
  import obi_bus_pkg::*;

  localparam int PtrWidth = (RspDepth > 1) ? $clog2(RspDepth) : 1;
  localparam int CntWidth = $clog2(RspDepth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  typedef struct packed {
    word_t rdata;
    logic  err;
    logic  exokay;
  } rsp_data_t;

  id_t       id_mem   [RspDepth];
  rsp_data_t data_mem [RspDepth];
  ptr_t      id_wr_q, id_rd_q, data_wr_q, data_rd_q;
  cnt_t      id_cnt_q, data_cnt_q;
  logic      wb_last_q;
  logic      id_empty, id_full, data_empty, data_full;
  logic      data_push, data_write, data_pop, pop;
  rsp_data_t data_in, data_out;

  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(RspDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign id_empty   = (id_cnt_q == '0);
  assign id_full    = (id_cnt_q == cnt_t'(RspDepth));
  assign data_empty = (data_cnt_q == '0);
  assign data_full  = (data_cnt_q == cnt_t'(RspDepth));

  // Every granted request holds an ID slot until its response leaves
  assign rsp_room_o = !id_full;

  // SC answers 0 on success and 1 on failure instead of the memory word
  assign data_in.rdata  = is_sc_q_i ? word_t'(!sc_ok_q_i) : mgr_rdata_i;
  assign data_in.err    = mgr_err_i;
  assign data_in.exokay = sc_ok_q_i;

  assign data_push  = mgr_rvalid_i && !wb_last_q;
  assign data_out   = data_empty ? data_in : data_mem[data_rd_q];
  assign pop        = rsp_o.rvalid && rready_i;
  assign data_pop   = pop && !data_empty;
  assign data_write = data_push && !(data_empty && pop);

  assign rsp_o = '{gnt: 1'b0, rvalid: !id_empty && (!data_empty || data_push),
                   rdata: data_out.rdata, rid: id_mem[id_rd_q],
                   err: data_out.err, exokay: data_out.exokay};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_last_q  <= 1'b0;
      id_wr_q    <= '0;
      id_rd_q    <= '0;
      id_cnt_q   <= '0;
      data_wr_q  <= '0;
      data_rd_q  <= '0;
      data_cnt_q <= '0;
    end else begin
      wb_last_q <= wb_issue_i;
      if (sbr_fire_i) id_wr_q <= next_ptr(id_wr_q);
      if (pop) id_rd_q <= next_ptr(id_rd_q);
      if (sbr_fire_i && !pop) begin
        id_cnt_q <= id_cnt_q + 1'b1;
      end else if (!sbr_fire_i && pop) begin
        id_cnt_q <= id_cnt_q - 1'b1;
      end
      if (data_write) data_wr_q <= next_ptr(data_wr_q);
      if (data_pop) data_rd_q <= next_ptr(data_rd_q);
      if (data_write && !data_pop) begin
        data_cnt_q <= data_cnt_q + 1'b1;
      end else if (!data_write && data_pop) begin
        data_cnt_q <= data_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sbr_fire_i) id_mem[id_wr_q] <= aid_i;
    if (data_write) data_mem[data_wr_q] <= data_in;
  end

  // Grant gating must leave room for every response in flight
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_push |-> !data_full)
    else $error("Read data pushed into a full response queue");

endmodule

`default_nettype wire

//--- verilog/obi_atop_resolver.sv
// OBI atomic resolver
// Turns RISC-V atomics on the subordinate port into plain reads and writes
// on the manager port, for a memory region it owns exclusively.

`default_nettype none

module obi_atop_resolver #(
  parameter bit LrScEnable = 1'b1,
  parameter int RspDepth   = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  obi_bus_pkg::sbr_req_t sbr_req_i,
  output obi_bus_pkg::sbr_rsp_t sbr_rsp_o,
  output obi_bus_pkg::mgr_req_t mgr_req_o,
  input  obi_bus_pkg::mgr_rsp_t mgr_rsp_i
);
  import atop_pkg::*;
  import obi_bus_pkg::*;

  logic     sbr_fire, sbr_gnt, sc_we, is_sc_q, sc_ok_q;
  logic     amo_busy, amo_rd, wb_gnt, wb_issue, rsp_room;
  addr_t    wb_addr;
  id_t      wb_aid;
  word_t    wb_data;
  sbr_rsp_t queue_rsp;

  atop_lrsc_monitor #(.LrScEnable(LrScEnable)) atop_lrsc_monitor_i (
    .clk_i, .rst_ni, .sbr_fire_i(sbr_fire), .we_i(sbr_req_i.we),
    .addr_i(sbr_req_i.addr), .aid_i(sbr_req_i.aid), .atop_i(sbr_req_i.atop),
    .sc_we_o(sc_we), .is_sc_q_o(is_sc_q), .sc_ok_q_o(sc_ok_q)
  );

  atop_amo_unit atop_amo_unit_i (
    .clk_i, .rst_ni, .sbr_fire_i(sbr_fire), .atop_i(sbr_req_i.atop),
    .addr_i(sbr_req_i.addr), .aid_i(sbr_req_i.aid), .wdata_i(sbr_req_i.wdata),
    .rvalid_i(mgr_rsp_i.rvalid), .rdata_i(mgr_rsp_i.rdata), .wb_gnt_i(wb_gnt),
    .amo_busy_o(amo_busy), .amo_rd_o(amo_rd), .wb_addr_o(wb_addr),
    .wb_aid_o(wb_aid), .wb_data_o(wb_data)
  );

  atop_req_arbiter atop_req_arbiter_i (
    .sbr_req_i, .mgr_gnt_i(mgr_rsp_i.gnt), .rsp_room_i(rsp_room), .sc_we_i(sc_we),
    .amo_busy_i(amo_busy), .amo_rd_i(amo_rd), .wb_addr_i(wb_addr), .wb_aid_i(wb_aid),
    .wb_data_i(wb_data), .mgr_req_o, .sbr_gnt_o(sbr_gnt), .sbr_fire_o(sbr_fire),
    .wb_gnt_o(wb_gnt), .wb_issue_o(wb_issue)
  );

  atop_rsp_queue #(.RspDepth(RspDepth)) atop_rsp_queue_i (
    .clk_i, .rst_ni, .sbr_fire_i(sbr_fire), .aid_i(sbr_req_i.aid),
    .wb_issue_i(wb_issue), .mgr_rvalid_i(mgr_rsp_i.rvalid), .mgr_rdata_i(mgr_rsp_i.rdata),
    .mgr_err_i(mgr_rsp_i.err), .is_sc_q_i(is_sc_q), .sc_ok_q_i(sc_ok_q),
    .rready_i(sbr_req_i.rready), .rsp_o(queue_rsp), .rsp_room_o(rsp_room)
  );

  // The grant comes from the arbiter, the rest of the response from the queue
  assign sbr_rsp_o = '{gnt: sbr_gnt, rvalid: queue_rsp.rvalid, rdata: queue_rsp.rdata,
                       rid: queue_rsp.rid, err: queue_rsp.err, exokay: queue_rsp.exokay};

endmodule

`default_nettype wire

//--- verilog/obi_bus_pkg.sv
// OBI bus types
// Widths and request/response structs of the subordinate and manager sides
// of the atomic resolver.

`default_nettype none

package obi_bus_pkg;

  parameter int AddrWidth = 32;
  parameter int IdWidth   = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [3:0]           be_t;

  // Subordinate side, carries the atomic opcode and the response ready
  typedef struct packed {
    logic            req;
    logic            we;
    addr_t           addr;
    atop_pkg::word_t wdata;
    be_t             be;
    id_t             aid;
    atop_pkg::atop_e atop;
    logic            rready;
  } sbr_req_t;

  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    atop_pkg::word_t rdata;
    id_t             rid;
    logic            err;
    logic            exokay;
  } sbr_rsp_t;

  // Manager side toward memory, plain reads and writes only
  typedef struct packed {
    logic            req;
    logic            we;
    addr_t           addr;
    atop_pkg::word_t wdata;
    be_t             be;
    id_t             aid;
  } mgr_req_t;

  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    atop_pkg::word_t rdata;
    logic            err;
  } mgr_rsp_t;

endpackage

`default_nettype wire
